//--- project.f
+incdir+bench
common/soc_pkg.sv
logic/bus_arbiter.sv
logic/bus_slice.sv
logic/addr_decoder.sv
memory/boot_rom.sv
memory/data_ram.sv
timer/clint_timer.sv
logic/soc_fabric_top.sv
bench/tb_soc_fabric.sv

//--- Bender.yml
package:
  name: soc_fabric

sources:
  - common/soc_pkg.sv
  - logic/bus_arbiter.sv
  - logic/bus_slice.sv
  - logic/addr_decoder.sv
  - memory/boot_rom.sv
  - memory/data_ram.sv
  - timer/clint_timer.sv
  - logic/soc_fabric_top.sv
  - target: simulation
    include_dirs:
      - bench
    files:
      - bench/tb_soc_fabric.sv

//--- bench/tb_soc_tasks.svh
// Needs clk, req_drv, req_valid and req_ready in scope; RAM reads must target words already written
`ifndef TB_SOC_TASKS_SVH
`define TB_SOC_TASKS_SVH

typedef struct packed {
    logic [31:0] data;
    logic        err;
    logic        check_data;
} exp_t;

exp_t        exp_q [2][$];
logic [31:0] last_rdata [2];
logic [31:0] ram_model [int];
logic        msip_model;
logic [31:0] mtimecmp_model;

// ------------------------------
// Reference model
// ------------------------------
function automatic soc_pkg::target_e target_of(input logic [31:0] addr);
    if (addr >= soc_pkg::ROM_BASE && addr < soc_pkg::ROM_BASE + soc_pkg::ROM_LENGTH) begin
        return soc_pkg::TGT_ROM;
    end
    if (addr >= soc_pkg::RAM_BASE && addr < soc_pkg::RAM_BASE + 32'(RAM_WORDS * 4)) begin
        return soc_pkg::TGT_RAM;
    end
    if (addr >= soc_pkg::CLINT_BASE &&
        addr < soc_pkg::CLINT_BASE + soc_pkg::CLINT_LENGTH) begin
        return soc_pkg::TGT_CLINT;
    end
    return soc_pkg::TGT_NONE;
endfunction

// ROM word i is the tag over the index i
function automatic logic [31:0] rom_word(input logic [31:0] addr);
    logic [31:0] idx;
    idx = (addr - soc_pkg::ROM_BASE) >> 2;
    return {soc_pkg::ROM_TAG, idx[15:0]};
endfunction

// Enabled lanes come from the write data
function automatic logic [31:0] merge_lanes(
    input logic [31:0] cur,
    input logic [31:0] wr,
    input logic [3:0]  be
);
    logic [31:0] mask;
    mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    return (cur & ~mask) | (wr & mask);
endfunction

// Expected answer and model update for writes
task automatic predict(input soc_pkg::bus_req_t r, output exp_t e);
    int          idx;
    logic [31:0] word;
    e = '{data: 32'h0, err: 1'b0, check_data: 1'b1};
    case (target_of(r.addr))
        soc_pkg::TGT_ROM: begin
            if (r.we) begin
                e.err        = 1'b1;
                e.check_data = 1'b0;
            end else begin
                e.data = rom_word(r.addr);
            end
        end
        soc_pkg::TGT_RAM: begin
            idx = int'((r.addr - soc_pkg::RAM_BASE) >> 2);
            if (r.we) begin
                word = ram_model.exists(idx) ? ram_model[idx] : 32'hx;
                ram_model[idx] = merge_lanes(word, r.wdata, r.be);
                e.check_data   = 1'b0;
            end else begin
                e.data = ram_model[idx];
            end
        end
        soc_pkg::TGT_CLINT: begin
            if (r.we) begin
                e.check_data = 1'b0;
                if (r.addr[15:0] == soc_pkg::MSIP_OFFSET && r.be[0]) begin
                    msip_model = r.wdata[0];
                end
                if (r.addr[15:0] == soc_pkg::MTIMECMP_OFFSET) begin
                    mtimecmp_model = merge_lanes(mtimecmp_model, r.wdata, r.be);
                end
            end else if (r.addr[15:0] == soc_pkg::MSIP_OFFSET) begin
                e.data = {31'h0, msip_model};
            end else if (r.addr[15:0] == soc_pkg::MTIMECMP_OFFSET) begin
                e.data = mtimecmp_model;
            end else if (r.addr[15:0] == soc_pkg::MTIME_OFFSET) begin
                e.check_data = 1'b0;
            end
        end
        default: e.err = 1'b1;
    endcase
endtask

// ------------------------------
// Bus tasks
// ------------------------------
// Leaves valid high so that the next call follows back to back
task automatic issue(
    input int          m,
    input logic [31:0] addr,
    input logic        we,
    input logic [3:0]  be,
    input logic [31:0] wdata
);
    soc_pkg::bus_req_t r;
    exp_t              e;
    r.addr  = addr;
    r.we    = we;
    r.be    = be;
    r.wdata = wdata;
    // Deliberately wrong tag for the arbiter to overwrite
    r.mst   = soc_pkg::mst_id_t'(m == 0);
    @(negedge clk);
    req_drv[m]   = r;
    req_valid[m] = 1'b1;
    #1;
    while (!req_ready[m]) begin
        @(negedge clk);
        #1;
    end
    predict(r, e);
    exp_q[m].push_back(e);
endtask

task automatic drain(input int m);
    @(negedge clk);
    req_valid[m] = 1'b0;
    while (exp_q[m].size() != 0) begin
        @(negedge clk);
    end
endtask

// Full write, random-lane write, then read-back of one RAM word
task automatic ram_rmw(input int m, input int unsigned idx);
    logic [31:0] addr;
    addr = soc_pkg::RAM_BASE + 32'(idx) * 4;
    issue(m, addr, 1'b1, 4'hf, $urandom);
    issue(m, addr, 1'b1, 4'($urandom), $urandom);
    issue(m, addr, 1'b0, 4'h0, 32'h0);
endtask

`endif

//--- bench/tb_soc_fabric.sv
// Runs six bus tests on both master ports; rtc_i runs at a tenth of the clock
`timescale 1ns/100ps
`default_nettype none

module tb_soc_fabric;

    localparam int RAM_WORDS = 1024;
    // Longest sequence is near 2000 cycles, so allow about twice that
    localparam int SEQ_CYCLES     = 2000;
    localparam int TIMEOUT_CYCLES = 2 * SEQ_CYCLES;

    logic              clk;
    logic              reset;
    logic              rtc;
    soc_pkg::bus_req_t req_drv [2];
    soc_pkg::bus_rsp_t rsp_mon [2];
    logic [1:0]        req_valid, req_ready, rsp_valid, rsp_ready;
    logic              ipi, timer_irq;
    logic              stall_en;
    int                error_count, test_errors, tests_passed, tests_failed;
    int                test_num, cycle_count;
    int                wait_grants [2];

    `include "tb_soc_tasks.svh"

    soc_fabric_top #(.RAM_WORDS(RAM_WORDS)) dut0 (
        .clk_i(clk), .reset_i(reset), .rtc_i(rtc),
        .core_req_i(req_drv[0]), .core_req_valid_i(req_valid[0]),
        .core_req_ready_o(req_ready[0]),
        .core_rsp_o(rsp_mon[0]), .core_rsp_valid_o(rsp_valid[0]),
        .core_rsp_ready_i(rsp_ready[0]),
        .dbg_req_i(req_drv[1]), .dbg_req_valid_i(req_valid[1]),
        .dbg_req_ready_o(req_ready[1]),
        .dbg_rsp_o(rsp_mon[1]), .dbg_rsp_valid_o(rsp_valid[1]),
        .dbg_rsp_ready_i(rsp_ready[1]),
        .ipi_o(ipi), .timer_irq_o(timer_irq)
    );

    task automatic flag_error(input string msg);
        error_count++;
        $display("** Error at %0t ns: %s", $time, msg);
    endtask

    task automatic end_test(input string name);
        test_num++;
        if (error_count == test_errors) begin
            tests_passed++;
            $display("test %0d %s: pass", test_num, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: FAIL", test_num, name);
        end
        test_errors = error_count;
    endtask

    // ------------------------------
    // Protocol assertions
    // ------------------------------
    for (genvar m = 0; m < 2; m++) begin : g_hold
        assert property (@(posedge clk) disable iff (reset)
            rsp_valid[m] && !rsp_ready[m] |=> rsp_valid[m] && $stable(rsp_mon[m]))
            else flag_error($sformatf("response on port %0d changed before accept", m));
    end

    assert property (@(posedge clk)
        reset |=> !(|rsp_valid || |req_ready || ipi || timer_irq))
        else flag_error("outputs not at reset values");

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        rtc = 1'b0;
        forever begin
            repeat (5) @(negedge clk);
            rtc = ~rtc;
        end
    end

    initial begin
        rsp_ready = 2'b11;
        forever begin
            @(negedge clk);
            rsp_ready = stall_en ? 2'($urandom) : 2'b11;
        end
    end

    // Response checks and grant fairness sampled mid-cycle
    initial begin
        exp_t e;
        wait_grants = '{0, 0};
        forever begin
            @(negedge clk);
            #2;
            for (int m = 0; m < 2; m++) begin
                if (rsp_valid[m] && rsp_ready[m]) begin
                    if (exp_q[m].size() == 0) begin
                        flag_error($sformatf("unexpected response on port %0d", m));
                    end else begin
                        e = exp_q[m].pop_front();
                        last_rdata[m] = rsp_mon[m].rdata;
                        assert (rsp_mon[m].err == e.err &&
                                (!e.check_data || rsp_mon[m].rdata === e.data))
                            else flag_error($sformatf("port %0d got %h err %b, expected %h err %b",
                                m, rsp_mon[m].rdata, rsp_mon[m].err, e.data, e.err));
                    end
                end
                if (req_ready[m]) begin
                    wait_grants[m] = 0;
                end else if (req_valid[m] && req_ready[1-m]) begin
                    wait_grants[m]++;
                end
                assert (wait_grants[m] <= 2)
                    else flag_error($sformatf("port %0d starved by the arbiter", m));
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Some tests failed");
            $finish;
        end
    end

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial begin
        logic [31:0] addr;
        logic [31:0] t;
        void'($urandom(32'hee9b_2ebe));
        {error_count, test_errors, tests_passed, tests_failed, test_num, cycle_count} = '0;
        req_drv        = '{default: '0};
        req_valid      = 2'b00;
        stall_en       = 1'b0;
        msip_model     = 1'b0;
        mtimecmp_model = '1;
        reset          = 1'b1;
        repeat (8) @(negedge clk);
        reset = 1'b0;
        repeat (2) @(negedge clk);

        repeat (16) ram_rmw(0, $urandom_range(0, RAM_WORDS - 1));
        drain(0);
        end_test("core RAM byte-enable write and read");

        repeat (8) issue(1, soc_pkg::ROM_BASE + 32'($urandom_range(0, 1023)) * 4, 0, 0, 0);
        addr = soc_pkg::ROM_BASE + 32'($urandom_range(0, 1023)) * 4;
        issue(1, addr, 1'b1, 4'hf, $urandom);
        issue(1, addr, 1'b0, 4'h0, 32'h0);
        drain(1);
        end_test("debug ROM read and write rejection");

        issue(0, 32'h4000_0000 | (32'($urandom) & 32'h0fff_fffc), 1'b0, 4'h0, 32'h0);
        issue(0, 32'h0000_0100, 1'b1, 4'hf, $urandom);
        drain(0);
        issue(1, soc_pkg::RAM_BASE + 32'(RAM_WORDS * 4), 1'b0, 4'h0, 32'h0);
        drain(1);
        end_test("unmapped access error");

        fork
            begin
                repeat (8) ram_rmw(0, $urandom_range(0, RAM_WORDS / 2 - 1));
                drain(0);
            end
            begin
                repeat (8) ram_rmw(1, $urandom_range(RAM_WORDS / 2, RAM_WORDS - 1));
                drain(1);
            end
        join
        end_test("concurrent masters");

        issue(0, soc_pkg::CLINT_BASE + soc_pkg::MSIP_OFFSET, 1'b0, 4'h0, 32'h0);
        issue(0, soc_pkg::CLINT_BASE + soc_pkg::MTIMECMP_OFFSET, 1'b0, 4'h0, 32'h0);
        issue(0, soc_pkg::CLINT_BASE + soc_pkg::MSIP_OFFSET, 1'b1, 4'h1, 32'h1);
        drain(0);
        assert (ipi) else flag_error("ipi_o low after msip set");
        issue(0, soc_pkg::CLINT_BASE + soc_pkg::MSIP_OFFSET, 1'b1, 4'h1, 32'h0);
        drain(0);
        assert (!ipi) else flag_error("ipi_o high after msip clear");
        issue(0, soc_pkg::CLINT_BASE + soc_pkg::MTIME_OFFSET, 1'b0, 4'h0, 32'h0);
        drain(0);
        t = last_rdata[0] + 32'd3;
        issue(0, soc_pkg::CLINT_BASE + soc_pkg::MTIMECMP_OFFSET, 1'b1, 4'hf, t);
        drain(0);
        repeat (2) @(negedge clk);
        assert (!timer_irq) else flag_error("timer_irq_o high before mtimecmp reached");
        // Three rtc edges need about 30 cycles
        for (int c = 0; c < 100 && !timer_irq; c++) begin
            @(negedge clk);
        end
        assert (timer_irq) else flag_error("timer_irq_o did not rise");
        end_test("timer and software interrupt");

        stall_en = 1'b1;
        repeat (12) ram_rmw(0, $urandom_range(0, RAM_WORDS - 1));
        drain(0);
        stall_en = 1'b0;
        end_test("response back-pressure");

        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (error_count == 0 && tests_failed == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- logic/soc_fabric_top.sv
// Two masters, one outstanding answer per pipeline stage; RAM_WORDS a power of two from 16
`timescale 1ns/100ps
`default_nettype none

module soc_fabric_top #(
    parameter int unsigned RAM_WORDS = 1024
) (
    input  logic              clk_i,
    input  logic              reset_i,
    input  logic              rtc_i,
    input  soc_pkg::bus_req_t core_req_i,
    input  logic              core_req_valid_i,
    output logic              core_req_ready_o,
    output soc_pkg::bus_rsp_t core_rsp_o,
    output logic              core_rsp_valid_o,
    input  logic              core_rsp_ready_i,
    input  soc_pkg::bus_req_t dbg_req_i,
    input  logic              dbg_req_valid_i,
    output logic              dbg_req_ready_o,
    output soc_pkg::bus_rsp_t dbg_rsp_o,
    output logic              dbg_rsp_valid_o,
    input  logic              dbg_rsp_ready_i,
    output logic              ipi_o,
    output logic              timer_irq_o
);

    soc_pkg::bus_req_t              arb_req, dec_req, tgt_req;
    logic                           arb_req_valid, arb_req_ready;
    logic                           dec_req_valid, dec_req_ready;
    soc_pkg::bus_rsp_t              dec_rsp, arb_rsp;
    logic                           dec_rsp_valid, dec_rsp_ready;
    logic                           arb_rsp_valid, arb_rsp_ready;
    logic                           rom_sel, ram_sel, clint_sel, rom_err;
    logic [soc_pkg::DATA_WIDTH-1:0] rom_rdata, ram_rdata, clint_rdata;

    // ------------------------------
    // Arbiter and pipeline
    // ------------------------------
    bus_arbiter i_bus_arbiter (
        .clk_i, .reset_i,
        .core_req_i, .core_req_valid_i, .core_req_ready_o,
        .dbg_req_i, .dbg_req_valid_i, .dbg_req_ready_o,
        .bus_req_o(arb_req), .bus_req_valid_o(arb_req_valid), .bus_req_ready_i(arb_req_ready),
        .bus_rsp_i(arb_rsp), .bus_rsp_valid_i(arb_rsp_valid), .bus_rsp_ready_o(arb_rsp_ready),
        .core_rsp_o, .core_rsp_valid_o, .core_rsp_ready_i,
        .dbg_rsp_o, .dbg_rsp_valid_o, .dbg_rsp_ready_i
    );

    bus_slice #(.payload_t(soc_pkg::bus_req_t)) i_req_slice (
        .clk_i, .reset_i,
        .in_i(arb_req), .in_valid_i(arb_req_valid), .in_ready_o(arb_req_ready),
        .out_o(dec_req), .out_valid_o(dec_req_valid), .out_ready_i(dec_req_ready)
    );

    addr_decoder #(.RAM_WORDS(RAM_WORDS)) i_addr_decoder (
        .clk_i, .reset_i,
        .req_i(dec_req), .req_valid_i(dec_req_valid), .req_ready_o(dec_req_ready),
        .rom_sel_o(rom_sel), .ram_sel_o(ram_sel), .clint_sel_o(clint_sel),
        .tgt_req_o(tgt_req),
        .rom_rdata_i(rom_rdata), .ram_rdata_i(ram_rdata), .clint_rdata_i(clint_rdata),
        .rom_err_i(rom_err),
        .rsp_o(dec_rsp), .rsp_valid_o(dec_rsp_valid), .rsp_ready_i(dec_rsp_ready)
    );

    bus_slice #(.payload_t(soc_pkg::bus_rsp_t)) i_rsp_slice (
        .clk_i, .reset_i,
        .in_i(dec_rsp), .in_valid_i(dec_rsp_valid), .in_ready_o(dec_rsp_ready),
        .out_o(arb_rsp), .out_valid_o(arb_rsp_valid), .out_ready_i(arb_rsp_ready)
    );

    // ------------------------------
    // Targets
    // ------------------------------
    boot_rom i_boot_rom (
        .clk_i, .sel_i(rom_sel), .req_i(tgt_req), .rdata_o(rom_rdata), .err_o(rom_err)
    );

    data_ram #(.RAM_WORDS(RAM_WORDS)) i_data_ram (
        .clk_i, .sel_i(ram_sel), .req_i(tgt_req), .rdata_o(ram_rdata)
    );

    clint_timer i_clint_timer (
        .clk_i, .reset_i, .rtc_i,
        .sel_i(clint_sel), .req_i(tgt_req), .rdata_o(clint_rdata),
        .ipi_o, .timer_irq_o
    );

endmodule

`default_nettype wire

//--- timer/clint_timer.sv
// Single hart; 32-bit mtime is read-only and wraps, rtc_i must be slower than half of clk_i
`timescale 1ns/100ps
`default_nettype none

module clint_timer (
    input  logic                           clk_i,
    input  logic                           reset_i,
    input  logic                           rtc_i,
    input  logic                           sel_i,
    input  soc_pkg::bus_req_t              req_i,
    output logic [soc_pkg::DATA_WIDTH-1:0] rdata_o,
    output logic                           ipi_o,
    output logic                           timer_irq_o
);

    logic [2:0]                     rtc_q;
    logic                           rtc_rise;
    logic                           msip_q;
    logic [soc_pkg::DATA_WIDTH-1:0] mtimecmp_q;
    logic [soc_pkg::DATA_WIDTH-1:0] mtime_q;
    logic                           irq_q;
    logic [15:0]                    ofs;
    logic                           wr;

    assign ofs = req_i.addr[15:0];
    assign wr  = sel_i & req_i.we;

    // ------------------------------
    // RTC synchronizer and counter
    // ------------------------------
    // Two sync flops then one for edge detect
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rtc_q <= '0;
        end else begin
            rtc_q <= {rtc_q[1:0], rtc_i};
        end
    end

    assign rtc_rise = rtc_q[1] & ~rtc_q[2];

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            mtime_q <= '0;
        end else if (rtc_rise) begin
            mtime_q <= mtime_q + 1'b1;
        end
    end

    // ------------------------------
    // Register file
    // ------------------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            msip_q     <= 1'b0;
            mtimecmp_q <= '1;
        end else if (wr) begin
            if (ofs == soc_pkg::MSIP_OFFSET && req_i.be[0]) begin
                msip_q <= req_i.wdata[0];
            end
            if (ofs == soc_pkg::MTIMECMP_OFFSET) begin
                mtimecmp_q <= soc_pkg::merge_be(mtimecmp_q, req_i.wdata, req_i.be);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (sel_i) begin
            case (ofs)
                soc_pkg::MSIP_OFFSET:     rdata_o <= {{(soc_pkg::DATA_WIDTH-1){1'b0}}, msip_q};
                soc_pkg::MTIMECMP_OFFSET: rdata_o <= mtimecmp_q;
                soc_pkg::MTIME_OFFSET:    rdata_o <= mtime_q;
                default:                  rdata_o <= '0;
            endcase
        end
    end

    // Compare registered one cycle behind the counters
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            irq_q <= 1'b0;
        end else begin
            irq_q <= (mtime_q >= mtimecmp_q);
        end
    end

    assign ipi_o       = msip_q;
    assign timer_irq_o = irq_q;

endmodule

`default_nettype wire

//--- memory/data_ram.sv
// RAM_WORDS must be a power of two, at least 16; contents are undefined until written
`timescale 1ns/100ps
`default_nettype none

module data_ram #(
    parameter int unsigned RAM_WORDS = 1024
) (
    input  logic                           clk_i,
    input  logic                           sel_i,
    input  soc_pkg::bus_req_t              req_i,
    output logic [soc_pkg::DATA_WIDTH-1:0] rdata_o
);

    localparam int unsigned OFS_W = $clog2(soc_pkg::BE_WIDTH);
    localparam int unsigned IDX_W = $clog2(RAM_WORDS);

    logic [soc_pkg::DATA_WIDTH-1:0] mem_q [RAM_WORDS];
    logic [IDX_W-1:0]               idx;

    // Word index sits just above the byte offset
    assign idx = req_i.addr[IDX_W+OFS_W-1:OFS_W];

    // ------------------------------
    // Byte-lane write port
    // ------------------------------
    always_ff @(posedge clk_i) begin
        if (sel_i && req_i.we) begin
            for (int b = 0; b < soc_pkg::BE_WIDTH; b++) begin
                if (req_i.be[b]) begin
                    mem_q[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
                end
            end
        end
    end

    // Read returns the word as it was before this access
    always_ff @(posedge clk_i) begin
        if (sel_i) begin
            rdata_o <= mem_q[idx];
        end
    end

endmodule

`default_nettype wire

//--- memory/boot_rom.sv
// Contents are computed from the word index, not loaded; writes are refused with an error
`timescale 1ns/100ps
`default_nettype none

module boot_rom (
    input  logic                           clk_i,
    input  logic                           sel_i,
    input  soc_pkg::bus_req_t              req_i,
    output logic [soc_pkg::DATA_WIDTH-1:0] rdata_o,
    output logic                           err_o
);

    localparam int unsigned OFS_W  = $clog2(soc_pkg::BE_WIDTH);
    localparam int unsigned WORD_W = $clog2(soc_pkg::ROM_LENGTH / soc_pkg::BE_WIDTH);

    logic [WORD_W-1:0] word_idx;
    logic [15:0]       low_half;

    assign word_idx = req_i.addr[WORD_W+OFS_W-1:OFS_W];
    assign low_half = 16'(word_idx);

    // Tag in the upper half, word index in the lower half
    always_ff @(posedge clk_i) begin
        if (sel_i) begin
            err_o <= req_i.we;
            if (req_i.we) begin
                rdata_o <= '0;
            end else begin
                rdata_o <= {soc_pkg::ROM_TAG, low_half};
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/addr_decoder.sv
// Targets must answer one cycle after the strobe and hold their answer until the next strobe
`timescale 1ns/100ps
`default_nettype none

module addr_decoder #(
    parameter int unsigned RAM_WORDS = 1024
) (
    input  logic                                clk_i,
    input  logic                                reset_i,
    input  soc_pkg::bus_req_t                   req_i,
    input  logic                                req_valid_i,
    output logic                                req_ready_o,
    output logic                                rom_sel_o,
    output logic                                ram_sel_o,
    output logic                                clint_sel_o,
    output soc_pkg::bus_req_t                   tgt_req_o,
    input  logic [soc_pkg::DATA_WIDTH-1:0]      rom_rdata_i,
    input  logic [soc_pkg::DATA_WIDTH-1:0]      ram_rdata_i,
    input  logic [soc_pkg::DATA_WIDTH-1:0]      clint_rdata_i,
    input  logic                                rom_err_i,
    output soc_pkg::bus_rsp_t                   rsp_o,
    output logic                                rsp_valid_o,
    input  logic                                rsp_ready_i
);

    localparam logic [soc_pkg::ADDR_WIDTH-1:0] RAM_LENGTH =
        soc_pkg::ADDR_WIDTH'(RAM_WORDS * soc_pkg::BE_WIDTH);

    soc_pkg::target_e tgt;
    soc_pkg::target_e tgt_q;
    soc_pkg::mst_id_t mst_q;
    logic             valid_q;
    logic             accept;

    // ------------------------------
    // Request stage
    // ------------------------------
    always_comb begin
        if ((req_i.addr - soc_pkg::ROM_BASE) < soc_pkg::ROM_LENGTH) begin
            tgt = soc_pkg::TGT_ROM;
        end else if ((req_i.addr - soc_pkg::RAM_BASE) < RAM_LENGTH) begin
            tgt = soc_pkg::TGT_RAM;
        end else if ((req_i.addr - soc_pkg::CLINT_BASE) < soc_pkg::CLINT_LENGTH) begin
            tgt = soc_pkg::TGT_CLINT;
        end else begin
            tgt = soc_pkg::TGT_NONE;
        end
    end

    // Pending answer moves on only when the response slice takes it
    assign req_ready_o = rsp_ready_i;
    assign accept      = req_valid_i & rsp_ready_i;

    assign rom_sel_o   = accept & (tgt == soc_pkg::TGT_ROM);
    assign ram_sel_o   = accept & (tgt == soc_pkg::TGT_RAM);
    assign clint_sel_o = accept & (tgt == soc_pkg::TGT_CLINT);
    assign tgt_req_o   = req_i;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_q <= 1'b0;
        end else if (rsp_ready_i) begin
            valid_q <= req_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            tgt_q <= tgt;
            mst_q <= req_i.mst;
        end
    end

    // ------------------------------
    // Response merge
    // ------------------------------
    always_comb begin
        rsp_o.rdata = '0;
        rsp_o.err   = 1'b0;
        rsp_o.mst   = mst_q;
        case (tgt_q)
            soc_pkg::TGT_ROM: begin
                rsp_o.rdata = rom_rdata_i;
                rsp_o.err   = rom_err_i;
            end
            soc_pkg::TGT_RAM:   rsp_o.rdata = ram_rdata_i;
            soc_pkg::TGT_CLINT: rsp_o.rdata = clint_rdata_i;
            default:            rsp_o.err   = 1'b1;
        endcase
    end

    assign rsp_valid_o = valid_q;

endmodule

`default_nettype wire

//--- logic/bus_slice.sv
// One entry deep; full throughput only while the consumer keeps ready high
`timescale 1ns/100ps
`default_nettype none

module bus_slice #(
    parameter type payload_t = logic
) (
    input  logic     clk_i,
    input  logic     reset_i,
    input  payload_t in_i,
    input  logic     in_valid_i,
    output logic     in_ready_o,
    output payload_t out_o,
    output logic     out_valid_o,
    input  logic     out_ready_i
);

    logic     full_q;
    payload_t data_q;

    // Room when empty or when the held entry leaves now
    assign in_ready_o = ~full_q | out_ready_i;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            full_q <= 1'b0;
        end else if (in_ready_o) begin
            full_q <= in_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (in_valid_i && in_ready_o) begin
            data_q <= in_i;
        end
    end

    assign out_o       = data_q;
    assign out_valid_o = full_q;

endmodule

`default_nettype wire

//--- logic/bus_arbiter.sv
// Two masters only; ready is raised only for a valid, granted request, responses routed by tag
`timescale 1ns/100ps
`default_nettype none

module bus_arbiter (
    input  logic              clk_i,
    input  logic              reset_i,
    input  soc_pkg::bus_req_t core_req_i,
    input  logic              core_req_valid_i,
    output logic              core_req_ready_o,
    input  soc_pkg::bus_req_t dbg_req_i,
    input  logic              dbg_req_valid_i,
    output logic              dbg_req_ready_o,
    output soc_pkg::bus_req_t bus_req_o,
    output logic              bus_req_valid_o,
    input  logic              bus_req_ready_i,
    input  soc_pkg::bus_rsp_t bus_rsp_i,
    input  logic              bus_rsp_valid_i,
    output logic              bus_rsp_ready_o,
    output soc_pkg::bus_rsp_t core_rsp_o,
    output logic              core_rsp_valid_o,
    input  logic              core_rsp_ready_i,
    output soc_pkg::bus_rsp_t dbg_rsp_o,
    output logic              dbg_rsp_valid_o,
    input  logic              dbg_rsp_ready_i
);

    soc_pkg::mst_id_t last_q;
    logic             pick_dbg;
    logic             rsp_to_dbg;

    // ------------------------------
    // Request side
    // ------------------------------
    // Debug wins alone, or when core had the last handshake
    assign pick_dbg = dbg_req_valid_i &
                      (~core_req_valid_i | (last_q == soc_pkg::MST_CORE));

    always_comb begin
        bus_req_o     = pick_dbg ? dbg_req_i : core_req_i;
        bus_req_o.mst = pick_dbg ? soc_pkg::MST_DBG : soc_pkg::MST_CORE;
    end

    assign bus_req_valid_o  = core_req_valid_i | dbg_req_valid_i;
    assign core_req_ready_o = core_req_valid_i & ~pick_dbg & bus_req_ready_i;
    assign dbg_req_ready_o  = pick_dbg & bus_req_ready_i;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            last_q <= soc_pkg::MST_DBG;
        end else if (bus_req_valid_o && bus_req_ready_i) begin
            last_q <= bus_req_o.mst;
        end
    end

    // ------------------------------
    // Response side
    // ------------------------------
    assign rsp_to_dbg = (bus_rsp_i.mst == soc_pkg::MST_DBG);

    assign core_rsp_o       = bus_rsp_i;
    assign dbg_rsp_o        = bus_rsp_i;
    assign core_rsp_valid_o = bus_rsp_valid_i & ~rsp_to_dbg;
    assign dbg_rsp_valid_o  = bus_rsp_valid_i & rsp_to_dbg;
    assign bus_rsp_ready_o  = rsp_to_dbg ? dbg_rsp_ready_i : core_rsp_ready_i;

endmodule

`default_nettype wire

//--- common/soc_pkg.sv
// Single-beat 32-bit bus only; mtime and mtimecmp are 32 bits, RAM window length set at top level
`default_nettype none

package soc_pkg;

    // ------------------------------
    // Bus widths
    // ------------------------------
    localparam int unsigned ADDR_WIDTH = 32;
    localparam int unsigned DATA_WIDTH = 32;
    localparam int unsigned BE_WIDTH   = DATA_WIDTH / 8;

    // ------------------------------
    // Address map
    // ------------------------------
    localparam logic [ADDR_WIDTH-1:0] ROM_BASE     = 32'h0001_0000;
    localparam logic [ADDR_WIDTH-1:0] ROM_LENGTH   = 32'h0000_1000;
    localparam logic [ADDR_WIDTH-1:0] CLINT_BASE   = 32'h0200_0000;
    localparam logic [ADDR_WIDTH-1:0] CLINT_LENGTH = 32'h0001_0000;
    localparam logic [ADDR_WIDTH-1:0] RAM_BASE     = 32'h8000_0000;

    // Offsets inside the timer window
    localparam logic [15:0] MSIP_OFFSET     = 16'h0000;
    localparam logic [15:0] MTIMECMP_OFFSET = 16'h4000;
    localparam logic [15:0] MTIME_OFFSET    = 16'hBFF8;

    // Upper half of every boot ROM word
    localparam logic [15:0] ROM_TAG = 16'hb007;

    typedef enum logic {
        MST_CORE = 1'b0,
        MST_DBG  = 1'b1
    } mst_id_t;

    typedef enum logic [1:0] {
        TGT_NONE,
        TGT_ROM,
        TGT_RAM,
        TGT_CLINT
    } target_e;

    typedef struct packed {
        logic [ADDR_WIDTH-1:0] addr;
        logic                  we;
        logic [BE_WIDTH-1:0]   be;
        logic [DATA_WIDTH-1:0] wdata;
        mst_id_t               mst;
    } bus_req_t;

    typedef struct packed {
        logic [DATA_WIDTH-1:0] rdata;
        logic                  err;
        mst_id_t               mst;
    } bus_rsp_t;

    // Replace only the byte lanes whose enable is set
    function automatic logic [DATA_WIDTH-1:0] merge_be(
        input logic [DATA_WIDTH-1:0] old_data,
        input logic [DATA_WIDTH-1:0] new_data,
        input logic [BE_WIDTH-1:0]   be
    );
        logic [DATA_WIDTH-1:0] result;
        result = old_data;
        for (int b = 0; b < BE_WIDTH; b++) begin
            if (be[b]) begin
                result[8*b +: 8] = new_data[8*b +: 8];
            end
        end
        return result;
    endfunction

endpackage

`default_nettype wire
